// ==== source/ras_pkg.sv ====
package ras_pkg;

	// ############################################################
	// widths and depth
	// ############################################################

	localparam int xlen             = 32;
	localparam int stack_addr_width = 4;
	localparam int stack_depth      = 1 << stack_addr_width;

	// register numbers.
	localparam logic [4:0] reg_zero = 5'd0;
	localparam logic [4:0] reg_ra   = 5'd1;

	// rv32i major opcodes.
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_op_imm = 7'b0010011;

	localparam logic [2:0] funct3_addi = 3'b000;

	// top pointer offsets, two's complement.
	localparam logic [stack_addr_width-1:0] off_zero    = 4'h0;
	localparam logic [stack_addr_width-1:0] off_pos_one = 4'h1;
	localparam logic [stack_addr_width-1:0] off_neg_one = 4'hf;
	localparam logic [stack_addr_width-1:0] off_neg_two = 4'he;

	// ############################################################
	// instruction word, seen as J-type or I-type
	// ############################################################

	typedef union packed {
		struct packed {
			logic [19:0] imm;    // scrambled jump offset.
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} j_view;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_view;
	} insn_word_u;

endpackage

// ==== source/circular_stack.sv ====
`timescale 1ns/1ps

module circular_stack #(
	parameter int WIDTH = 32,
	parameter logic [WIDTH-1:0] init_value = '0
) (
	input  logic                                  clk,
	input  logic                                  rst_n,

	input  logic                                  data_wr,
	input  logic [WIDTH-1:0]                      data_in,

	input  logic                                  offset_en,
	input  logic [ras_pkg::stack_addr_width-1:0]  offset,

	output logic [WIDTH-1:0]                      data_out
);

	logic [ras_pkg::stack_addr_width-1:0] top_ptr;
	logic [ras_pkg::stack_addr_width-1:0] top_ptr_next;
	logic [WIDTH-1:0]                     regs [ras_pkg::stack_depth];

	// wraps modulo depth.
	assign top_ptr_next = offset_en ? top_ptr + offset : top_ptr;

	assign data_out = regs[top_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			top_ptr <= '0;
			for (int i = 0; i < ras_pkg::stack_depth; i++) begin
				regs[i] <= init_value;
			end
		end else begin
			top_ptr <= top_ptr_next;
			if (data_wr) begin
				regs[top_ptr_next] <= data_in;   // write lands at the new top.
			end
		end
	end

endmodule

// ==== source/return_stack.sv ====
`timescale 1ns/1ps

module return_stack (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     push,
	input  logic                     pop,
	input  logic                     rollback_push_id,
	input  logic                     rollback_pop_id,
	input  logic                     rollback_push_ex,

	input  logic [ras_pkg::xlen-1:0] return_addr,

	input  logic                     ra_track_wr,
	input  logic [4:0]               rd_new,

	output logic [ras_pkg::xlen-1:0] predicted_target,
	output logic [4:0]               ra_track
);

	logic [ras_pkg::stack_addr_width-1:0] offset;
	logic                                 offset_en;
	logic                                 restore_wr;
	logic                                 push_sel;
	logic                                 pop_sel;

	logic                                 addr_wr;
	logic                                 track_wr;
	logic [ras_pkg::xlen-1:0]             addr_data;
	logic [4:0]                           track_data;

	logic [ras_pkg::xlen-1:0]             saved_addr;
	logic [4:0]                           saved_track;

	// ############################################################
	// offset select
	// ############################################################

	// rollbacks outrank fetch; only one branch can fire.
	always_comb begin
		offset     = ras_pkg::off_zero;
		offset_en  = 1'b0;
		restore_wr = 1'b0;
		push_sel   = 1'b0;
		pop_sel    = 1'b0;
		if (rollback_pop_id && rollback_push_ex) begin
			offset_en  = 1'b1;   // undo both, same top.
			restore_wr = 1'b1;
		end else if (rollback_push_id && rollback_push_ex) begin
			offset     = ras_pkg::off_neg_two;
			offset_en  = 1'b1;
		end else if (rollback_pop_id) begin
			offset     = ras_pkg::off_pos_one;
			offset_en  = 1'b1;
			restore_wr = 1'b1;   // put the popped entry back.
		end else if (rollback_push_id || rollback_push_ex) begin
			offset     = ras_pkg::off_neg_one;
			offset_en  = 1'b1;
		end else if (push) begin
			offset     = ras_pkg::off_pos_one;
			offset_en  = 1'b1;
			push_sel   = 1'b1;
		end else if (pop) begin
			offset     = ras_pkg::off_neg_one;
			offset_en  = 1'b1;
			pop_sel    = 1'b1;
		end
	end

	// last popped entry, for pop rollback.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			saved_addr  <= '0;
			saved_track <= ras_pkg::reg_ra;
		end else if (pop_sel) begin
			saved_addr  <= predicted_target;
			saved_track <= ra_track;
		end
	end

	// ############################################################
	// write data
	// ############################################################

	assign addr_wr   = push_sel || restore_wr;
	assign track_wr  = addr_wr || ra_track_wr;

	assign addr_data  = push_sel ? return_addr : saved_addr;
	assign track_data = ra_track_wr ? rd_new :
	                    push_sel    ? ras_pkg::reg_ra : saved_track;

	circular_stack #(
		.WIDTH      (ras_pkg::xlen),
		.init_value ('0)
	) addr_stack (
		.clk       (clk),
		.rst_n     (rst_n),
		.data_wr   (addr_wr),
		.data_in   (addr_data),
		.offset_en (offset_en),
		.offset    (offset),
		.data_out  (predicted_target)
	);

	// moves in step with addr_stack.
	circular_stack #(
		.WIDTH      (5),
		.init_value (ras_pkg::reg_ra)
	) ra_track_stack (
		.clk       (clk),
		.rst_n     (rst_n),
		.data_wr   (track_wr),
		.data_in   (track_data),
		.offset_en (offset_en),
		.offset    (offset),
		.data_out  (ra_track)
	);

endmodule

// ==== source/link_decoder.sv ====
`timescale 1ns/1ps

module link_decoder (
	input  logic                     fetch_valid,
	input  logic [ras_pkg::xlen-1:0] fetch_pc,
	input  ras_pkg::insn_word_u      fetch_insn,

	input  logic [4:0]               ra_track,

	output logic                     push,
	output logic                     pop,
	output logic                     ra_track_wr,
	output logic [4:0]               rd_new,
	output logic [ras_pkg::xlen-1:0] return_addr,
	output logic                     return_hit
);

	logic [6:0] opcode;
	logic       is_jal;
	logic       is_jalr;
	logic       is_addi;

	logic [4:0] j_rd;
	logic [4:0] i_rd;
	logic [4:0] i_rs1;
	logic       rs1_is_track;

	// opcode sits in the same bits in both views.
	assign opcode = fetch_insn.j_view.opcode;

	assign is_jal  = fetch_valid && (opcode == ras_pkg::opc_jal);
	assign is_jalr = fetch_valid && (opcode == ras_pkg::opc_jalr);
	assign is_addi = fetch_valid && (opcode == ras_pkg::opc_op_imm) &&
	                 (fetch_insn.i_view.funct3 == ras_pkg::funct3_addi);

	assign j_rd  = fetch_insn.j_view.rd;
	assign i_rd  = fetch_insn.i_view.rd;
	assign i_rs1 = fetch_insn.i_view.rs1;

	assign rs1_is_track = (i_rs1 == ra_track);

	// ############################################################
	// link events
	// ############################################################

	// call: jal ra, target.
	assign push = is_jal && (j_rd == ras_pkg::reg_ra);

	// return through whichever register holds the link.
	assign pop = is_jalr && (i_rd == ras_pkg::reg_zero) && rs1_is_track;

	assign return_hit = pop;

	// mv rd, link.
	assign ra_track_wr = is_addi && rs1_is_track &&
	                     (fetch_insn.i_view.imm == 12'd0) &&
	                     (i_rd != ras_pkg::reg_zero);

	assign rd_new = i_rd;

	assign return_addr = fetch_pc + ras_pkg::xlen'(4);

endmodule

// ==== source/ras_top.sv ====
`timescale 1ns/1ps

module ras_top (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     fetch_valid,
	input  logic [ras_pkg::xlen-1:0] fetch_pc,
	input  ras_pkg::insn_word_u      fetch_insn,

	input  logic                     rollback_push_id,
	input  logic                     rollback_pop_id,
	input  logic                     rollback_push_ex,

	output logic [ras_pkg::xlen-1:0] predicted_target,
	output logic                     return_hit
);

	logic                     push;
	logic                     pop;
	logic                     ra_track_wr;
	logic [4:0]               rd_new;
	logic [ras_pkg::xlen-1:0] return_addr;
	logic [4:0]               ra_track;

	// ############################################################
	// fetch-side decode
	// ############################################################

	link_decoder u_link_decoder (
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_insn  (fetch_insn),
		.ra_track    (ra_track),   // fed back from the stack top.
		.push        (push),
		.pop         (pop),
		.ra_track_wr (ra_track_wr),
		.rd_new      (rd_new),
		.return_addr (return_addr),
		.return_hit  (return_hit)
	);

	// ############################################################
	// stack
	// ############################################################

	return_stack u_return_stack (
		.clk              (clk),
		.rst_n            (rst_n),
		.push             (push),
		.pop              (pop),
		.rollback_push_id (rollback_push_id),
		.rollback_pop_id  (rollback_pop_id),
		.rollback_push_ex (rollback_push_ex),
		.return_addr      (return_addr),
		.ra_track_wr      (ra_track_wr),
		.rd_new           (rd_new),
		.predicted_target (predicted_target),
		.ra_track         (ra_track)
	);

endmodule

// ==== verification/tb_ras_top.sv ====
`timescale 1ns/1ps

module tb_ras_top;

	logic        clk;
	logic        rst_n;
	logic        fetch_valid;
	logic [31:0] fetch_pc;
	logic [31:0] fetch_insn;
	logic        rollback_push_id;
	logic        rollback_pop_id;
	logic        rollback_push_ex;
	logic [31:0] predicted_target;
	logic        return_hit;

	// reference stack, one entry per slot.
	logic [31:0] m_addr [0:15];
	logic [4:0]  m_track [0:15];
	logic [3:0]  m_top;
	logic [31:0] sv_addr;
	logic [4:0]  sv_track;

	logic [31:0] last_target;
	logic        last_hit;
	int          check_count;
	int          error_count;
	int          test_count;
	int          test_errors_at_start;

	ras_top DUT (
		.clk              (clk),
		.rst_n            (rst_n),
		.fetch_valid      (fetch_valid),
		.fetch_pc         (fetch_pc),
		.fetch_insn       (fetch_insn),
		.rollback_push_id (rollback_push_id),
		.rollback_pop_id  (rollback_pop_id),
		.rollback_push_ex (rollback_push_ex),
		.predicted_target (predicted_target),
		.return_hit       (return_hit)
	);

	always #4 clk = ~clk;

	// ############################################################
	// encoders and random stimulus
	// ############################################################

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'h000, rs1, 3'b000, rd, 7'b1100111};
	endfunction

	function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
	                                         input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] rand_pc();
		logic [31:0] r;
		r = $urandom();
		return {r[31:2], 2'b00};
	endfunction

	// mostly ra, the tracked register or x0.
	function automatic logic [4:0] pick_reg(input logic [4:0] track);
		logic [31:0] r;
		r = $urandom();
		case (r[1:0])
			2'd0:    return 5'd1;
			2'd1:    return track;
			2'd2:    return 5'd0;
			default: return r[8:4];
		endcase
	endfunction

	function automatic logic [31:0] rand_insn(input logic [4:0] track);
		int unsigned kind;
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		kind = $urandom_range(0, 9);
		r    = $urandom();
		rd   = pick_reg(track);
		rs1  = pick_reg(track);
		case (kind)
			0, 1, 2: return enc_jal(rd, r[19:0]);
			3, 4, 5: return enc_jalr(r[5] ? 5'd0 : rd, rs1);
			6, 7:    return enc_addi(rd, rs1, (r[3:2] != 2'd0) ? 12'd0 : r[31:20]);
			default: return {r[31:7], r[6] ? 7'b0110011 : 7'b0000011};
		endcase
	endfunction

	// ############################################################
	// checks and reference model
	// ############################################################

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic model_reset();
		for (int i = 0; i < 16; i++) begin
			m_addr[i]  = 32'd0;
			m_track[i] = 5'd1;
		end
		m_top    = 4'd0;
		sv_addr  = 32'd0;
		sv_track = 5'd1;
	endtask

	// compares this cycle, then applies the next edge.
	task automatic check_and_advance();
		logic [6:0]  opc;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  cur_track;
		logic        e_push;
		logic        e_pop;
		logic        e_tw;
		logic [3:0]  off;
		logic [3:0]  nt;
		logic        restore;
		logic [31:0] old_sv_addr;
		logic [4:0]  old_sv_track;
		opc       = fetch_insn[6:0];
		rd        = fetch_insn[11:7];
		rs1       = fetch_insn[19:15];
		cur_track = m_track[m_top];
		e_push = fetch_valid && (opc == 7'b1101111) && (rd == 5'd1);
		e_pop  = fetch_valid && (opc == 7'b1100111) && (rd == 5'd0) && (rs1 == cur_track);
		e_tw   = fetch_valid && (opc == 7'b0010011) && (fetch_insn[14:12] == 3'b000) &&
		         (rs1 == cur_track) && (fetch_insn[31:20] == 12'd0) && (rd != 5'd0);
		last_hit    = return_hit;
		last_target = predicted_target;
		check_value("return_hit", {31'd0, return_hit}, {31'd0, e_pop});
		check_value("predicted_target", predicted_target, m_addr[m_top]);

		off          = 4'd0;
		restore      = 1'b0;
		old_sv_addr  = sv_addr;
		old_sv_track = sv_track;
		if (rollback_pop_id && rollback_push_ex) begin
			restore = 1'b1;
		end else if (rollback_push_id && rollback_push_ex) begin
			off = 4'he;
		end else if (rollback_pop_id) begin
			off     = 4'd1;
			restore = 1'b1;
		end else if (rollback_push_id || rollback_push_ex) begin
			off = 4'hf;
		end else if (e_push) begin
			off = 4'd1;
		end else if (e_pop) begin
			off      = 4'hf;
			sv_addr  = m_addr[m_top];
			sv_track = m_track[m_top];
		end
		nt = m_top + off;
		if (restore) begin
			m_addr[nt]  = old_sv_addr;
			m_track[nt] = old_sv_track;
		end else if (e_push && !(rollback_push_id || rollback_push_ex)) begin
			m_addr[nt]  = fetch_pc + 32'd4;
			m_track[nt] = 5'd1;
		end
		if (e_tw) begin
			m_track[nt] = rd;
		end
		m_top = nt;
	endtask

	task automatic drive_cycle(input logic valid, input logic [31:0] pc, input logic [31:0] insn,
	                           input logic rb_push_id, input logic rb_pop_id,
	                           input logic rb_push_ex);
		@(posedge clk);
		fetch_valid      <= valid;
		fetch_pc         <= pc;
		fetch_insn       <= insn;
		rollback_push_id <= rb_push_id;
		rollback_pop_id  <= rb_pop_id;
		rollback_push_ex <= rb_push_ex;
		@(negedge clk);
		check_and_advance();
	endtask

	task automatic call_at(input logic [31:0] pc);
		drive_cycle(1'b1, pc, enc_jal(5'd1, 20'h00010), 1'b0, 1'b0, 1'b0);
	endtask

	task automatic copy_link(input logic [4:0] rd);
		drive_cycle(1'b1, rand_pc(), enc_addi(rd, 5'd1, 12'd0), 1'b0, 1'b0, 1'b0);
	endtask

	// fetch is squashed while a rollback is high.
	task automatic rollback(input logic pid, input logic pop, input logic pex);
		drive_cycle(1'b0, 32'd0, 32'h0000_0013, pid, pop, pex);
	endtask

	task automatic return_expect(input logic [4:0] rs1, input logic exp_hit,
	                             input logic [31:0] exp_target);
		drive_cycle(1'b1, rand_pc(), enc_jalr(5'd0, rs1), 1'b0, 1'b0, 1'b0);
		check_value("return_hit", {31'd0, last_hit}, {31'd0, exp_hit});
		if (exp_hit) begin
			check_value("predicted_target", last_target, exp_target);
		end
	endtask

	task automatic start_test();
		test_errors_at_start = error_count;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %0d (%s) done, %0d errors", test_count, name,
		         error_count - test_errors_at_start);
	endtask

	// ############################################################
	// main sequence
	// ############################################################

	initial begin
		int unsigned waited;
		int unsigned r;
		logic [31:0] pcs [0:19];
		clk         = 1'b0;
		check_count = 0;
		error_count = 0;
		test_count  = 0;
		void'($urandom(32'h695f_e186));
		rst_n            <= 1'b0;
		fetch_valid      <= 1'b0;
		fetch_pc         <= 32'd0;
		fetch_insn       <= 32'h0000_0013;
		rollback_push_id <= 1'b0;
		rollback_pop_id  <= 1'b0;
		rollback_push_ex <= 1'b0;
		model_reset();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		waited = 0;
		while (!rst_n) begin
			@(negedge clk);
			waited++;
			if (waited > 20) begin
				$display("reset was not released within 20 cycles");
				$display("TEST FAILED");
				$finish;
			end
		end

		start_test();
		return_expect(5'd1, 1'b1, 32'd0);
		finish_test("return after reset");

		start_test();
		for (int i = 0; i < 40; i++) begin
			r = $urandom_range(0, 1);
			if (r == 0) begin
				call_at(rand_pc());
			end else begin
				drive_cycle(1'b1, rand_pc(), enc_jalr(5'd0, m_track[m_top]), 1'b0, 1'b0, 1'b0);
			end
		end
		for (int i = 0; i < 20; i++) begin
			pcs[i] = 32'h0000_8000 + 32'(i) * 32'h100;
			call_at(pcs[i]);
		end
		for (int k = 0; k < 16; k++) begin
			return_expect(5'd1, 1'b1, pcs[19 - k] + 32'd4);
		end
		return_expect(5'd1, 1'b1, pcs[19] + 32'd4);   // oldest slots were overwritten.
		finish_test("calls and returns");

		start_test();
		call_at(32'h0000_1000);
		call_at(32'h0000_2000);
		call_at(32'h0000_3000);
		rollback(1'b1, 1'b0, 1'b0);
		return_expect(5'd1, 1'b1, 32'h0000_2004);
		call_at(32'h0000_3100);
		call_at(32'h0000_3200);
		rollback(1'b1, 1'b0, 1'b1);
		return_expect(5'd1, 1'b1, 32'h0000_1004);
		call_at(32'h0000_3300);
		call_at(32'h0000_3400);
		rollback(1'b0, 1'b0, 1'b1);
		return_expect(5'd1, 1'b1, 32'h0000_3304);
		finish_test("push rollback");

		start_test();
		call_at(32'h0000_4000);
		call_at(32'h0000_5000);
		return_expect(5'd1, 1'b1, 32'h0000_5004);
		rollback(1'b0, 1'b1, 1'b0);
		return_expect(5'd1, 1'b1, 32'h0000_5004);
		return_expect(5'd1, 1'b1, 32'h0000_4004);
		call_at(32'h0000_5100);
		call_at(32'h0000_5200);
		return_expect(5'd1, 1'b1, 32'h0000_5204);
		call_at(32'h0000_5300);
		rollback(1'b0, 1'b1, 1'b1);   // wrong-path call and pop both undone.
		return_expect(5'd1, 1'b1, 32'h0000_5204);
		return_expect(5'd1, 1'b1, 32'h0000_5104);
		finish_test("pop rollback");

		start_test();
		call_at(32'h0000_6000);
		copy_link(5'd6);
		return_expect(5'd1, 1'b0, 32'd0);
		return_expect(5'd6, 1'b1, 32'h0000_6004);
		call_at(32'h0000_7000);
		copy_link(5'd6);
		call_at(32'h0000_7100);
		return_expect(5'd1, 1'b1, 32'h0000_7104);
		return_expect(5'd6, 1'b1, 32'h0000_7004);
		finish_test("link copies");

		start_test();
		for (int i = 0; i < 3000; i++) begin
			r = $urandom_range(0, 9);
			if (r < 2) begin
				r = $urandom_range(0, 7);
				rollback(r[0], r[1], r[2]);
			end else begin
				drive_cycle(1'b1, rand_pc(), rand_insn(m_track[m_top]), 1'b0, 1'b0, 1'b0);
			end
		end
		finish_test("mixed random");

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
source/ras_pkg.sv
source/circular_stack.sv
source/return_stack.sv
source/link_decoder.sv
source/ras_top.sv
verification/tb_ras_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ras_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
